/* include/checkers_cfg.svh */
`ifndef CHECKERS_CFG_SVH
`define CHECKERS_CFG_SVH

// Board geometry
`define BOARD_SIDE 8

// Input coordinate width, values of BOARD_SIDE and up are off the board
`define COORD_BITS 5

// One square code
`define SQUARE_BITS 3

// Edits in flight between checker and updater, 2 or more
`define EDIT_QUEUE_DEPTH 4

`endif

/* logic/checkers_pkg.sv */
`include "checkers_cfg.svh"

package checkers_pkg;

    // Bit 1 marks player 2, bit 2 marks a king
    typedef enum logic [`SQUARE_BITS-1:0] {
        SQ_UNUSED  = 3'b000,
        SQ_P1_MAN  = 3'b001,
        SQ_P2_MAN  = 3'b010,
        SQ_P1_KING = 3'b101,
        SQ_P2_KING = 3'b110,
        SQ_EMPTY   = 3'b111
    } square_t;

    typedef logic [`COORD_BITS-1:0] coord_t;

    // Row times BOARD_SIDE plus column, row 0 at the bottom
    typedef logic [$clog2(`BOARD_SIDE * `BOARD_SIDE)-1:0] square_index_t;

    typedef square_t [`BOARD_SIDE * `BOARD_SIDE-1:0] board_t;

    typedef struct packed {
        coord_t sel_x;
        coord_t sel_y;
        coord_t tgt_x;
        coord_t tgt_y;
    } move_t;

    typedef struct packed {
        square_index_t index;
        square_t       value;
        logic          last;     // Final edit of a move
        logic          accepted; // Low only on a rejection
    } square_edit_t;

endpackage

/* logic/move_checker.sv */
`timescale 1ns/100ps
`include "checkers_cfg.svh"

module move_checker (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  checkers_pkg::board_t       board,
    input  logic                       turn,
    input  checkers_pkg::move_t        move,
    input  logic                       full,
    input  logic                       done,
    output logic                       busy,
    output logic                       push,
    output checkers_pkg::square_edit_t edit
);
    import checkers_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CAPTURE,
        ST_EVAL,
        ST_PUSH,
        ST_WAIT
    } state_t;

    // Position in the edit sequence of a move
    typedef enum logic [1:0] {
        SEQ_MID,
        SEQ_SEL,
        SEQ_TGT,
        SEQ_REJECT
    } seq_t;

    state_t state;
    seq_t   seq;

    move_t   mv_q;
    logic    turn_q;
    square_t sel_sq_q;
    square_t tgt_sq_q;
    logic    on_board_q;
    logic    is_step_q;
    logic    is_jump_q;

    coord_t        dx;
    coord_t        dy;
    square_index_t sel_idx;
    square_index_t tgt_idx;
    square_index_t mid_idx;
    logic          owned;
    logic          valid;
    square_t       tgt_val;

    function automatic square_index_t sq_index(coord_t x, coord_t y);
        return square_index_t'(y * `BOARD_SIDE + x);
    endfunction

    always_comb begin
        dx = (mv_q.sel_x > mv_q.tgt_x) ? mv_q.sel_x - mv_q.tgt_x : mv_q.tgt_x - mv_q.sel_x;
        dy = (mv_q.sel_y > mv_q.tgt_y) ? mv_q.sel_y - mv_q.tgt_y : mv_q.tgt_y - mv_q.sel_y;
        sel_idx = sq_index(mv_q.sel_x, mv_q.sel_y);
        tgt_idx = sq_index(mv_q.tgt_x, mv_q.tgt_y);
        // Jumped square sits halfway along the diagonal
        mid_idx = sq_index(coord_t'((mv_q.sel_x + mv_q.tgt_x) >> 1),
                           coord_t'((mv_q.sel_y + mv_q.tgt_y) >> 1));
    end

    always_comb begin
        if (turn_q)
            owned = (sel_sq_q == SQ_P1_MAN) || (sel_sq_q == SQ_P1_KING);
        else
            owned = (sel_sq_q == SQ_P2_MAN) || (sel_sq_q == SQ_P2_KING);
        valid = on_board_q && owned && (tgt_sq_q == SQ_EMPTY) && (is_step_q || is_jump_q);
        if (mv_q.tgt_y == 0 || mv_q.tgt_y == coord_t'(`BOARD_SIDE - 1))
            tgt_val = square_t'({1'b1, sel_sq_q[1:0]}); // Crowned, same color
        else
            tgt_val = sel_sq_q;
    end

    always_comb begin
        edit.last     = (seq == SEQ_TGT) || (seq == SEQ_REJECT);
        edit.accepted = (seq != SEQ_REJECT);
        case (seq)
            SEQ_MID: begin
                edit.index = mid_idx;
                edit.value = SQ_EMPTY;
            end
            SEQ_SEL: begin
                edit.index = sel_idx;
                edit.value = SQ_EMPTY;
            end
            SEQ_TGT: begin
                edit.index = tgt_idx;
                edit.value = tgt_val;
            end
            default: begin
                edit.index = tgt_idx; // Updater ignores a rejection's square
                edit.value = tgt_sq_q;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            mv_q   <= move;
            turn_q <= turn;
        end
        if (state == ST_CAPTURE) begin
            sel_sq_q   <= board[sel_idx];
            tgt_sq_q   <= board[tgt_idx];
            on_board_q <= (mv_q.sel_x < `BOARD_SIDE) && (mv_q.sel_y < `BOARD_SIDE) &&
                          (mv_q.tgt_x < `BOARD_SIDE) && (mv_q.tgt_y < `BOARD_SIDE);
            is_step_q  <= (dx == 1) && (dy == 1);
            is_jump_q  <= (dx == 2) && (dy == 2);
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= ST_IDLE;
            seq   <= SEQ_MID;
        end else begin
            case (state)
                ST_IDLE:    if (start) state <= ST_CAPTURE;
                ST_CAPTURE: state <= ST_EVAL;
                ST_EVAL: begin
                    if (!valid)
                        seq <= SEQ_REJECT;
                    else if (is_jump_q)
                        seq <= SEQ_MID;
                    else
                        seq <= SEQ_SEL;
                    state <= ST_PUSH;
                end
                ST_PUSH: begin
                    if (!full) begin
                        if (edit.last)
                            state <= ST_WAIT;
                        else
                            seq <= seq_t'(seq + 1); // Mid, then selected, then target
                    end
                end
                ST_WAIT:    if (done) state <= ST_IDLE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    assign busy = (state != ST_IDLE);
    assign push = (state == ST_PUSH);

endmodule

/* logic/edit_queue.sv */
`timescale 1ns/100ps
`include "checkers_cfg.svh"

module edit_queue (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,
    input  checkers_pkg::square_edit_t edit_in,
    input  logic                       pop,
    output logic                       full,
    output logic                       not_empty,
    output checkers_pkg::square_edit_t head
);
    import checkers_pkg::*;

    localparam int DEPTH = `EDIT_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    square_edit_t     mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Wraps at any depth, power of two or not
    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push   = push && !full;
    assign do_pop    = pop && not_empty;
    assign full      = (count == CNT_W'(DEPTH));
    assign not_empty = (count != '0);
    assign head      = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= edit_in;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

endmodule

/* logic/board_updater.sv */
`timescale 1ns/100ps

module board_updater (
    input  logic                       clk,
    input  logic                       rst,
    input  checkers_pkg::board_t       board,
    input  logic                       turn,
    input  logic                       not_empty,
    input  checkers_pkg::square_edit_t head,
    output logic                       pop,
    output logic                       done,
    output checkers_pkg::board_t       updated_board,
    output logic                       updated_turn
);
    import checkers_pkg::*;

    board_t work_q;
    board_t base;
    board_t edited;
    logic   in_move_q; // Some edits of the current move already applied

    // Drain whatever the queue offers
    assign pop = not_empty;

    always_comb begin
        base               = in_move_q ? work_q : board;
        edited             = base;
        edited[head.index] = head.value;
    end

    // Between moves the copy tracks the input board
    always_ff @(posedge clk) begin
        work_q <= pop ? edited : base;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            in_move_q     <= 1'b0;
            done          <= 1'b0;
            updated_board <= board_t'('0);
            updated_turn  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (pop) begin
                in_move_q <= !head.last;
                if (head.last) begin
                    done <= 1'b1;
                    if (head.accepted) begin
                        updated_board <= edited;
                        updated_turn  <= !turn; // Other player's move next
                    end else begin
                        updated_board <= board;
                        updated_turn  <= turn;
                    end
                end
            end
        end
    end

endmodule

/* logic/piece_mover.sv */
`timescale 1ns/100ps

module piece_mover (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  checkers_pkg::board_t board,
    input  logic                 turn,
    input  checkers_pkg::move_t  move,
    output logic                 busy,
    output logic                 done,
    output checkers_pkg::board_t updated_board,
    output logic                 updated_turn
);
    import checkers_pkg::*;

    logic         push;
    logic         full;
    logic         not_empty;
    logic         pop;
    square_edit_t edit;
    square_edit_t head;

    move_checker u_checker (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .board (board),
        .turn  (turn),
        .move  (move),
        .full  (full),
        .done  (done),
        .busy  (busy),
        .push  (push),
        .edit  (edit)
    );

    edit_queue u_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .edit_in   (edit),
        .pop       (pop),
        .full      (full),
        .not_empty (not_empty),
        .head      (head)
    );

    board_updater u_updater (
        .clk           (clk),
        .rst           (rst),
        .board         (board),
        .turn          (turn),
        .not_empty     (not_empty),
        .head          (head),
        .pop           (pop),
        .done          (done),
        .updated_board (updated_board),
        .updated_turn  (updated_turn)
    );

endmodule

/* sim/piece_mover_checker.sv */
`timescale 1ns/100ps

module piece_mover_checker (
    input logic                 clk,
    input logic                 rst,
    input logic                 start,
    input logic                 busy,
    input logic                 done,
    input checkers_pkg::board_t updated_board,
    input logic                 updated_turn
);

    done_single_cycle: assert property (
        @(posedge clk) disable iff (!rst)
        done |=> !done
    ) else $error("done stayed high for more than one cycle");

    done_inside_busy: assert property (
        @(posedge clk) disable iff (!rst)
        done |-> busy
    ) else $error("done pulsed while busy was low");

    // An accepted start raises busy one cycle later
    busy_after_start: assert property (
        @(posedge clk) disable iff (!rst)
        (start && !busy) |=> busy
    ) else $error("busy did not rise after a start in idle");

    results_hold: assert property (
        @(posedge clk) disable iff (!rst)
        !done |-> ($stable(updated_board) && $stable(updated_turn))
    ) else $error("results changed outside the done cycle");

endmodule

bind piece_mover piece_mover_checker u_port_checks (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .busy          (busy),
    .done          (done),
    .updated_board (updated_board),
    .updated_turn  (updated_turn)
);

/* sim/piece_mover_tb.sv */
`timescale 1ns/100ps

module piece_mover_tb;
    import checkers_pkg::*;

    localparam int WORD_W        = $bits(board_t);
    localparam int FIELDS        = 9;   // Words per vector line
    localparam int MAX_VECTORS   = 32;
    localparam int VECTOR_CYCLES = 40;
    localparam int DONE_LIMIT    = 30;

    // Mode word of a vector line
    localparam int MODE_NEXT = 1;       // Start the cycle after the previous done
    localparam int MODE_BUSY = 2;       // Stray start while busy
    localparam int MODE_END  = 15;

    logic   clk;
    logic   rst;
    logic   start;
    board_t board;
    logic   turn;
    move_t  move;
    logic   busy;
    logic   done;
    board_t updated_board;
    logic   updated_turn;

    logic [WORD_W-1:0] vectors [MAX_VECTORS * FIELDS];
    int                num_vectors;
    int                passed;
    int                failed;
    logic              loaded;

    piece_mover u_dut (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .board         (board),
        .turn          (turn),
        .move          (move),
        .busy          (busy),
        .done          (done),
        .updated_board (updated_board),
        .updated_turn  (updated_turn)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Inputs change 1 ns after the rising edge
    task automatic advance_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_for_done(output logic seen);
        int cycles;
        cycles = 0;
        while (!done && cycles < DONE_LIMIT) begin
            advance_cycle();
            cycles++;
        end
        seen = done;
    endtask

    task automatic run_vector(input int n);
        int     base;
        int     mode;
        int     gap;
        logic   seen;
        logic   ok;
        board_t exp_board;
        logic   exp_turn;

        base      = n * FIELDS;
        mode      = int'(vectors[base][3:0]);
        exp_board = board_t'(vectors[base + 7]);
        exp_turn  = vectors[base + 8][0];
        ok        = 1'b1;

        if (mode != MODE_NEXT) begin
            gap = $urandom % 4;
            repeat (gap) advance_cycle();
        end
        advance_cycle();
        // Busy has already fallen the cycle after the previous done
        if (busy !== 1'b0) begin
            $display("ERROR at %0t: vector %0d busy %b before start, expected 0",
                     $time, n, busy);
            ok = 1'b0;
        end
        board      = board_t'(vectors[base + 6]);
        turn       = vectors[base + 1][0];
        move.sel_x = coord_t'(vectors[base + 2]);
        move.sel_y = coord_t'(vectors[base + 3]);
        move.tgt_x = coord_t'(vectors[base + 4]);
        move.tgt_y = coord_t'(vectors[base + 5]);
        start      = 1'b1;
        advance_cycle();
        start      = 1'b0;
        if (busy !== 1'b1) begin
            $display("ERROR at %0t: vector %0d busy %b after start, expected 1",
                     $time, n, busy);
            ok = 1'b0;
        end
        if (mode == MODE_BUSY) begin
            start = 1'b1; // Falls in the capture cycle
            advance_cycle();
            start = 1'b0;
        end

        wait_for_done(seen);
        if (!seen) begin
            $display("Vector %0d: no done pulse within %0d cycles", n, DONE_LIMIT);
            ok = 1'b0;
        end else begin
            if (updated_board !== exp_board) begin
                $display("ERROR at %0t: vector %0d board %h, expected %h",
                         $time, n, updated_board, exp_board);
                ok = 1'b0;
            end
            if (updated_turn !== exp_turn) begin
                $display("ERROR at %0t: vector %0d turn %b, expected %b",
                         $time, n, updated_turn, exp_turn);
                ok = 1'b0;
            end
        end

        if (ok) begin
            passed++;
            $display("Vector %0d (mode %0d): passed", n, mode);
        end else begin
            failed++;
            $display("Vector %0d (mode %0d): failed", n, mode);
        end
    endtask

    initial begin
        rst         = 1'b0;
        start       = 1'b0;
        board       = board_t'('0);
        turn        = 1'b0;
        move        = '0;
        passed      = 0;
        failed      = 0;
        num_vectors = 0;
        loaded      = 1'b0;
        void'($urandom(32'hdbca));

        $readmemh("sim/piece_mover_vectors.txt", vectors);
        while (num_vectors < MAX_VECTORS &&
               vectors[num_vectors * FIELDS] != WORD_W'(MODE_END))
            num_vectors++;
        loaded = 1'b1;

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;

        if (num_vectors == 0) begin
            $display("No test vectors could be read from the vector file");
            failed++;
        end
        for (int i = 0; i < num_vectors; i++)
            run_vector(i);

        $display("%0d vectors run, %0d passed, %0d failed", num_vectors, passed, failed);
        if (failed == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    // Run length scales with the vector count
    initial begin
        wait (loaded);
        repeat (num_vectors * VECTOR_CYCLES + 100) @(posedge clk);
        $display("Watchdog expired, the run did not finish in %0d cycles",
                 num_vectors * VECTOR_CYCLES + 100);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* sim/piece_mover_vectors.txt */
// mode turn sel_x sel_y tgt_x tgt_y board(row 7 .. row 0) expected_board expected_turn
// mode 0 random gap, 1 start the cycle after done, 2 extra start while busy, f ends the list
0 1 2 2 3 3 ffffff_ffffff_fd7fff_ffffff_ffffff_fffe7f_ffffff_ffffff ffffff_ffffff_fd7fff_ffffff_fff3ff_ffffff_ffffff_ffffff 0
1 0 4 3 5 4 ffffff_ffffff_ffffff_ffffff_ffefff_ffffff_ffffff_ffffcf ffffff_ffffff_ffffff_ff7fff_ffffff_ffffff_ffffff_ffffcf 1
2 1 1 1 3 3 ffffff_ffffff_ffffff_ffffff_ffffff_fffebf_ffffcf_ffffff ffffff_ffffff_ffffff_ffffff_fff3ff_ffffff_ffffff_ffffff 0
1 0 6 5 4 3 ffffff_ffffff_fbffff_feffff_ffffff_ffffff_ffffff_ffffff ffffff_ffffff_ffffff_ffffff_ffefff_ffffff_ffffff_ffffff 1
0 1 4 2 6 4 ffffff_ffffff_ffffff_ffffff_ffffff_ff9fff_ffffff_ffffff ffffff_ffffff_ffffff_e7ffff_ffffff_ffffff_ffffff_ffffff 0
2 1 3 6 4 7 ffffff_fff3ff_ffffff_ffffff_ffffff_ffffff_ffffff_ffffff ffdfff_ffffff_ffffff_ffffff_ffffff_ffffff_ffffff_ffffff 0
1 0 2 2 0 0 ffffff_ffffff_ffffff_ffffff_ffffff_fffebf_ffffcf_ffffff ffffff_ffffff_ffffff_ffffff_ffffff_ffffff_ffffff_fffffe 1
0 1 3 3 4 4 ffffff_ffffff_ffffff_ffffff_ffffff_fffe7f_ffffff_ffffff ffffff_ffffff_ffffff_ffffff_ffffff_fffe7f_ffffff_ffffff 1
1 1 5 5 4 4 ffffff_ffffff_fd7fff_ffffff_ffffff_ffffff_ffffff_ffffff ffffff_ffffff_fd7fff_ffffff_ffffff_ffffff_ffffff_ffffff 1
0 0 3 5 2 4 ffffff_ffffff_fff5ff_fffe7f_ffffff_ffffff_ffffff_ffffff ffffff_ffffff_fff5ff_fffe7f_ffffff_ffffff_ffffff_ffffff 0
2 1 2 2 2 3 ffffff_ffffff_ffffff_ffffff_ffffff_fffe7f_ffffff_ffffff ffffff_ffffff_ffffff_ffffff_ffffff_fffe7f_ffffff_ffffff 1
1 1 2 2 5 5 ffffff_ffffff_ffffff_ffffff_ffffff_fffe7f_ffffff_ffffff ffffff_ffffff_ffffff_ffffff_ffffff_fffe7f_ffffff_ffffff 1
0 0 7 1 8 0 ffffff_ffffff_ffffff_ffffff_ffffff_ffffff_5fffff_ffffff ffffff_ffffff_ffffff_ffffff_ffffff_ffffff_5fffff_ffffff 0
2 1 3 4 2 3 ffffff_ffffff_ffffff_fffbff_ffffff_ffffff_ffffff_ffffff ffffff_ffffff_ffffff_ffffff_ffff7f_ffffff_ffffff_ffffff 0
f

/* sim.f */
+incdir+include
logic/checkers_pkg.sv
logic/move_checker.sv
logic/edit_queue.sv
logic/board_updater.sv
logic/piece_mover.sv
sim/piece_mover_checker.sv
sim/piece_mover_tb.sv
